// ==== hdl/ciEncodingPkg.sv ====
package ciEncodingPkg;

  // custom-instruction port geometry
  localparam int ciNumberWidth = 8;
  localparam int ciWordWidth   = 32;

  // instruction numbers answered by the units
  localparam logic [ciNumberWidth-1:0] swapByteId   = 8'd1;
  localparam logic [ciNumberWidth-1:0] clockMeterId = 8'd4;
  localparam logic [ciNumberWidth-1:0] microDelayId = 8'd6;

  // operand of the byte swapper
  // bytes[3] is the most significant byte, halves[1] the upper half
  typedef union packed {
    logic [3:0][7:0]  bytes;   // full reversal view
    logic [1:0][15:0] halves;  // per-half swap view
  } swapWord;

endpackage

// ==== hdl/ciSubsystem.sv ====
`timescale 1ns/1ps

module ciSubsystem (
  input  logic                                    s_systemClock,
  input  logic                                    s_pllLocked,
  input  logic                                    referenceClock,
  input  logic [ciEncodingPkg::ciNumberWidth-1:0] ciN,
  input  logic [ciEncodingPkg::ciWordWidth-1:0]   ciDataA,
  input  logic [ciEncodingPkg::ciWordWidth-1:0]   ciDataB,
  input  logic                                    ciStart,
  output logic                                    ciDone,
  output logic [ciEncodingPkg::ciWordWidth-1:0]   ciResult,
  output logic                                    cpuReset
);

  import ciEncodingPkg::*;

  logic                   s_swapByteDone;
  logic [ciWordWidth-1:0] s_swapByteResult;
  logic                   s_delayDone;
  logic [ciWordWidth-1:0] s_delayResult;
  logic                   s_cpuFreqDone;
  logic [ciWordWidth-1:0] s_cpuFreqResult;

  // core held in reset until the pll has been stable for a while
  resetStretcher resetStretch (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset)
  );

  // instruction 1
  swapByteUnit swapByte (
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDataB (ciDataB),
    .ciStart (ciStart),
    .ciDone  (s_swapByteDone),
    .ciResult(s_swapByteResult)
  );

  // instruction 6, blocks for ciDataA microseconds
  microDelayUnit delayMicro (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciStart      (ciStart),
    .ciDone       (s_delayDone),
    .ciResult     (s_delayResult)
  );

  // instruction 4
  clockMeter cpuFreq (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .cpuReset      (cpuReset),
    .referenceClock(referenceClock),
    .ciN           (ciN),
    .ciStart       (ciStart),
    .ciDone        (s_cpuFreqDone),
    .ciResult      (s_cpuFreqResult)
  );

  // idle units drive zeros, so a plain OR merges the answers
  assign ciDone   = s_swapByteDone | s_delayDone | s_cpuFreqDone;
  assign ciResult = s_swapByteResult | s_delayResult | s_cpuFreqResult;

endmodule

// ==== hdl/clockMeter.sv ====
`timescale 1ns/1ps

module clockMeter (
  input  logic                                    s_systemClock,
  input  logic                                    s_pllLocked,
  input  logic                                    cpuReset,
  input  logic                                    referenceClock,
  input  logic [ciEncodingPkg::ciNumberWidth-1:0] ciN,
  input  logic                                    ciStart,
  output logic                                    ciDone,
  output logic [ciEncodingPkg::ciWordWidth-1:0]   ciResult
);

  import ciEncodingPkg::*;
  import timingPkg::*;

  logic [2:0]                 s_refSyncReg;   // two sync stages plus edge history
  logic                       s_refRise;
  logic [windowEdgeWidth-1:0] s_edgeCountReg;
  logic [meterCountWidth-1:0] s_clockCountReg;
  logic [meterCountWidth-1:0] s_latchedCountReg;
  logic                       s_windowEnd;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_refSyncReg <= '0;
    end else begin
      s_refSyncReg <= {s_refSyncReg[1:0], referenceClock};
    end
  end

  assign s_refRise   = s_refSyncReg[1] & ~s_refSyncReg[2];
  assign s_windowEnd = s_refRise &&
                       (s_edgeCountReg == windowEdgeWidth'(referenceWindowCycles - 1));

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_edgeCountReg    <= '0;
      s_clockCountReg   <= '0;
      s_latchedCountReg <= '0;
    end else if (cpuReset) begin
      s_edgeCountReg    <= '0;
      s_clockCountReg   <= '0;
      s_latchedCountReg <= '0;
    end else if (s_windowEnd) begin
      // include the closing cycle in the count
      s_latchedCountReg <= s_clockCountReg + 1'b1;
      s_clockCountReg   <= '0;
      s_edgeCountReg    <= '0;
    end else begin
      s_clockCountReg <= s_clockCountReg + 1'b1;
      if (s_refRise) begin
        s_edgeCountReg <= s_edgeCountReg + 1'b1;
      end
    end
  end

  assign ciDone   = ciStart && (ciN == clockMeterId);
  assign ciResult = ciDone ? s_latchedCountReg : '0;  // last completed window

endmodule

// ==== hdl/microDelayUnit.sv ====
`timescale 1ns/1ps

module microDelayUnit (
  input  logic                                    s_systemClock,
  input  logic                                    s_pllLocked,
  input  logic                                    cpuReset,
  input  logic [ciEncodingPkg::ciNumberWidth-1:0] ciN,
  input  logic [ciEncodingPkg::ciWordWidth-1:0]   ciDataA,
  input  logic                                    ciStart,
  output logic                                    ciDone,
  output logic [ciEncodingPkg::ciWordWidth-1:0]   ciResult
);

  import ciEncodingPkg::*;
  import timingPkg::*;

  logic                      s_busyReg;
  logic [ciWordWidth-1:0]    s_usCountReg;     // microseconds still to wait
  logic [prescalerWidth-1:0] s_prescalerReg;
  logic                      s_startDelay;
  logic                      s_prescalerWrap;
  logic                      s_countDone;

  assign s_startDelay    = ciStart && (ciN == microDelayId);
  assign s_prescalerWrap = (s_prescalerReg == prescalerWidth'(cyclesPerMicrosecond - 1));
  assign s_countDone     = (s_usCountReg == '0);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_busyReg      <= 1'b0;
      s_usCountReg   <= '0;
      s_prescalerReg <= '0;
    end else if (cpuReset) begin
      s_busyReg      <= 1'b0;
      s_usCountReg   <= '0;
      s_prescalerReg <= '0;
    end else if (s_startDelay) begin
      s_busyReg      <= 1'b1;
      s_usCountReg   <= ciDataA;
      s_prescalerReg <= '0;
    end else if (s_busyReg) begin
      if (s_countDone) begin
        s_busyReg <= 1'b0;  // done cycle, back to idle
      end else if (s_prescalerWrap) begin
        s_prescalerReg <= '0;
        s_usCountReg   <= s_usCountReg - 1'b1;
      end else begin
        s_prescalerReg <= s_prescalerReg + 1'b1;
      end
    end
  end

  // one cycle pulse as busy drops on the next edge
  assign ciDone = s_busyReg && s_countDone;

  // the instruction only blocks so the result stays zero
  assign ciResult = '0;

endmodule

// ==== hdl/resetStretcher.sv ====
`timescale 1ns/1ps

module resetStretcher (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset
);

  import timingPkg::*;

  logic [resetStretchBits-1:0] s_resetCountReg;
  logic                        s_released;

  assign s_released = s_resetCountReg[resetStretchBits-1];

  // counts up from lock, then sticks once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!s_released) begin
      s_resetCountReg <= s_resetCountReg + 1'b1;
    end
  end

  assign cpuReset = ~s_released;

endmodule

// ==== hdl/swapByteUnit.sv ====
`timescale 1ns/1ps

module swapByteUnit (
  input  logic [ciEncodingPkg::ciNumberWidth-1:0] ciN,
  input  logic [ciEncodingPkg::ciWordWidth-1:0]   ciDataA,
  input  logic [ciEncodingPkg::ciWordWidth-1:0]   ciDataB,
  input  logic                                    ciStart,
  output logic                                    ciDone,
  output logic [ciEncodingPkg::ciWordWidth-1:0]   ciResult
);

  import ciEncodingPkg::*;

  swapWord s_operand;
  swapWord s_swapped;
  logic    s_halfMode;

  assign s_operand  = ciDataA;
  assign s_halfMode = ciDataB[0];  // mode select, other bits ignored

  always_comb begin
    if (s_halfMode) begin
      // swap the two bytes inside each 16-bit half
      s_swapped.halves[1] = {s_operand.halves[1][7:0], s_operand.halves[1][15:8]};
      s_swapped.halves[0] = {s_operand.halves[0][7:0], s_operand.halves[0][15:8]};
    end else begin
      s_swapped.bytes = {s_operand.bytes[0], s_operand.bytes[1],
                         s_operand.bytes[2], s_operand.bytes[3]};  // full endian flip
    end
  end

  assign ciDone   = ciStart && (ciN == swapByteId);
  assign ciResult = ciDone ? s_swapped : '0;

endmodule

// ==== hdl/timingPkg.sv ====
package timingPkg;

  // top bit of the reset counter releases the core
  localparam int resetStretchBits = 5;

  // 50 MHz system clock
  localparam int cyclesPerMicrosecond = 50;
  localparam int prescalerWidth       = $clog2(cyclesPerMicrosecond);

  // meter window length in reference clock edges
  localparam int referenceWindowCycles = 100;
  localparam int windowEdgeWidth       = $clog2(referenceWindowCycles);
  localparam int meterCountWidth       = 32;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the custom-instruction testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f sources.f \
  --top-module ciSubsystemTb \
  -o ciSubsystemSim

./obj_dir/ciSubsystemSim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0

// ==== sources.f ====
+incdir+tests
hdl/ciEncodingPkg.sv
hdl/timingPkg.sv
hdl/resetStretcher.sv
hdl/swapByteUnit.sv
hdl/microDelayUnit.sv
hdl/clockMeter.sv
hdl/ciSubsystem.sv
tests/ciSubsystemTb.sv

// ==== tests/ciModel.svh ====
`ifndef CI_MODEL_SVH
`define CI_MODEL_SVH

// reference behavior of the custom instructions
localparam int modelStretchCycles = 16;   // core reset hold after lock
localparam int modelWindowEdges   = 100;  // reference edges per meter window
localparam int modelMeterSlack    = 2;    // sync and phase jitter

// byte reversal, or a byte swap inside each 16-bit half
function automatic logic [31:0] expectedSwap(input logic [31:0] word, input logic halfMode);
  logic [31:0] swapped;
  int i;
  swapped = '0;
  if (halfMode) begin
    for (i = 0; i < 2; i++) begin
      swapped[16*i +: 8]   = word[16*i+8 +: 8];
      swapped[16*i+8 +: 8] = word[16*i +: 8];
    end
  end else begin
    for (i = 0; i < 4; i++) begin
      swapped[8*i +: 8] = word[8*(3-i) +: 8];
    end
  end
  return swapped;
endfunction

// one microsecond is 1000 ns of system clock, plus the load cycle
function automatic int expectedDelayLatency(input logic [31:0] micros);
  return int'(micros) * (1000 / clockPeriodNs) + 1;
endfunction

function automatic int expectedMeterCount();
  return modelWindowEdges * referencePeriodNs / clockPeriodNs;
endfunction

function automatic bit meterCountOk(input logic [31:0] count);
  return (int'(count) >= expectedMeterCount() - modelMeterSlack) &&
         (int'(count) <= expectedMeterCount() + modelMeterSlack);
endfunction

`endif

// ==== tests/ciSubsystemTb.sv ====
`timescale 1ns/1ps

module ciSubsystemTb;

  import ciEncodingPkg::*;

  localparam int          clockPeriodNs     = 20;
  localparam int          referencePeriodNs = 50;
  localparam int          driveDelayNs      = 2;
  localparam int          resetCycles       = 10;
  localparam logic [15:0] lfsrSeed          = 16'd39671;
  localparam int          releaseTimeout    = 40;
  localparam int          answerTimeout     = 600;
  localparam int          silenceCycles     = 1000;
  localparam int          meterSettleCycles = 600;  // two windows and some margin

  `include "ciModel.svh"

  logic                     s_systemClock;
  logic                     s_pllLocked;
  logic                     referenceClock;
  logic [ciNumberWidth-1:0] ciN;
  logic [ciWordWidth-1:0]   ciDataA;
  logic [ciWordWidth-1:0]   ciDataB;
  logic                     ciStart;
  logic                     ciDone;
  logic [ciWordWidth-1:0]   ciResult;
  logic                     cpuReset;

  logic [15:0] lfsrState;
  int          errorCount;
  int          timeoutCount;
  int          runCycles = 0;  // cycles since core reset release

  ciSubsystem u_dut (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .referenceClock(referenceClock),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .ciStart       (ciStart),
    .ciDone        (ciDone),
    .ciResult      (ciResult),
    .cpuReset      (cpuReset)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(clockPeriodNs / 2) s_systemClock = ~s_systemClock;
  end

  initial begin
    referenceClock = 1'b0;
    forever #(referencePeriodNs / 2) referenceClock = ~referenceClock;
  end

  always @(posedge s_systemClock) begin
    if (cpuReset) runCycles <= 0;
    else runCycles <= runCycles + 1;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      bits      = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    errorCount++;
    $display("Error at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
  endtask

  task automatic reportTimeout(input string reason);
    timeoutCount++;
    $display("Timeout at time %0t: %s", $time, reason);
  endtask

  // one start pulse, then watch each cycle until done or the limit runs out
  task automatic runInstruction(
    input  logic [ciNumberWidth-1:0] number,
    input  logic [ciWordWidth-1:0]   dataA,
    input  logic [ciWordWidth-1:0]   dataB,
    input  int                       limit,
    output bit                       answered,
    output int                       latency,
    output logic [ciWordWidth-1:0]   result
  );
    answered = 1'b0;
    latency  = 0;
    result   = '0;
    @(posedge s_systemClock);
    #driveDelayNs;
    ciN     = number;
    ciDataA = dataA;
    ciDataB = dataB;
    ciStart = 1'b1;
    while (!answered && latency <= limit) begin
      @(negedge s_systemClock);
      if (ciDone) begin
        answered = 1'b1;
        result   = ciResult;
      end else begin
        if (ciResult != '0) reportMismatch("ciResult before ciDone", '0, ciResult);
        @(posedge s_systemClock);
        #driveDelayNs;
        ciStart = 1'b0;
        latency++;
      end
    end
    @(posedge s_systemClock);
    #driveDelayNs;
    ciStart = 1'b0;  // no second pulse after a same-cycle answer
  endtask

  task automatic checkAnswer(input string what, input bit answered, input int latency,
                             input int expLatency, input logic [31:0] result,
                             input logic [31:0] expResult);
    if (!answered) begin
      reportTimeout({what, " instruction got no ciDone"});
    end else begin
      if (latency != expLatency) reportMismatch({what, " ciDone latency"}, expLatency, latency);
      if (result != expResult) reportMismatch({what, " ciResult"}, expResult, result);
    end
  endtask

  initial begin
    logic [ciWordWidth-1:0]   dataA;
    logic [ciWordWidth-1:0]   dataB;
    logic [ciWordWidth-1:0]   result;
    logic [ciWordWidth-1:0]   word;
    logic [ciNumberWidth-1:0] unusedN;
    bit                       answered;
    bit                       released;
    int                       latency;
    int                       edges;
    int                       waited;
    int                       i;
    s_pllLocked  = 1'b0;
    ciN          = '0;
    ciDataA      = '0;
    ciDataB      = '0;
    ciStart      = 1'b0;
    lfsrState    = lfsrSeed;
    errorCount   = 0;
    timeoutCount = 0;

    // reset and the release of the core
    for (i = 0; i < resetCycles; i++) begin
      @(posedge s_systemClock);
      #driveDelayNs;
      if (cpuReset !== 1'b1) reportMismatch("cpuReset", 1, 32'(cpuReset));
      if (ciDone !== 1'b0) reportMismatch("ciDone", 0, 32'(ciDone));
    end
    s_pllLocked = 1'b1;
    edges    = 0;
    released = 1'b0;
    while (!released && edges < releaseTimeout) begin
      @(posedge s_systemClock);
      edges++;
      @(negedge s_systemClock);
      if (ciDone !== 1'b0) reportMismatch("ciDone", 0, 32'(ciDone));
      if (cpuReset === 1'b0) released = 1'b1;
    end
    if (!released) reportTimeout("cpuReset stayed high after lock");
    else if (edges != modelStretchCycles)
      reportMismatch("cpuReset release edge", modelStretchCycles, edges);

    for (i = 0; i < 12; i++) begin
      dataA    = takeBits(32);
      dataB    = takeBits(32);
      dataB[0] = i[0];  // alternate reversal and half swap
      runInstruction(swapByteId, dataA, dataB, 4, answered, latency, result);
      checkAnswer("swap", answered, latency, 0, result, expectedSwap(dataA, dataB[0]));
    end

    for (i = 0; i < 8; i++) begin
      dataA = takeBits(3);
      dataB = takeBits(32);
      runInstruction(microDelayId, dataA, dataB, answerTimeout, answered, latency, result);
      checkAnswer("delay", answered, latency, expectedDelayLatency(dataA), result, '0);
    end

    waited = 0;
    while (runCycles < meterSettleCycles && waited < meterSettleCycles + 10) begin
      @(posedge s_systemClock);
      waited++;
    end
    if (runCycles < meterSettleCycles) reportTimeout("meter windows never completed");
    for (i = 0; i < 3; i++) begin
      runInstruction(clockMeterId, takeBits(32), takeBits(32), 4, answered, latency, result);
      if (!answered) reportTimeout("meter instruction got no ciDone");
      else if (latency != 0) reportMismatch("meter ciDone latency", 0, latency);
      else if (!meterCountOk(result))
        reportMismatch("meter ciResult", expectedMeterCount(), result);
    end

    // unknown number must stay unanswered
    word    = takeBits(8);
    unusedN = word[7:0];
    if (unusedN == swapByteId || unusedN == clockMeterId || unusedN == microDelayId)
      unusedN = unusedN + 8'd16;
    runInstruction(unusedN, takeBits(32), takeBits(32), silenceCycles, answered, latency,
                   result);
    if (answered) begin
      errorCount++;
      $display("Unused instruction %0d was answered after %0d cycles", unusedN, latency);
    end
    dataA = takeBits(32);
    dataB = takeBits(32);
    runInstruction(swapByteId, dataA, dataB, 4, answered, latency, result);
    checkAnswer("swap after unused", answered, latency, 0, result,
                expectedSwap(dataA, dataB[0]));

    $display("errors %0d, timeouts %0d", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
